// ==== compile.f ====
scene_pkg.sv
instance_emitter.sv
scene_buffer.sv
scene_bounds.sv
scene_pipe_top.sv
scene_pipe_props.sv
tb_scene_pipe.sv

// ==== instance_emitter.sv ====
`timescale 1ns/100ps
`default_nettype none

module instance_emitter (
    input  wire logic                             clk,
    input  wire logic                             rstn,

    input  wire logic                             cmd_valid,
    output logic                                  cmd_ready,
    input  wire scene_pkg::scene_op_e             cmd_op,
    input  wire scene_pkg::model_id_t             cmd_model,
    input  wire scene_pkg::coord_t                cmd_x,
    input  wire scene_pkg::coord_t                cmd_y,
    input  wire scene_pkg::coord_t                cmd_step,
    input  wire logic [scene_pkg::count_w-1:0]    cmd_count,
    input  wire logic                             cmd_last,

    output logic                                  inst_valid,
    input  wire logic                             inst_ready,
    output scene_pkg::model_id_t                  inst_model,
    output scene_pkg::coord_t                     inst_x,
    output scene_pkg::coord_t                     inst_y,
    output logic                                  inst_last
);
    import scene_pkg::*;

    typedef enum logic {
        st_idle,
        st_emit
    } state_e;

    state_e                state;
    scene_op_e             op_q;
    model_id_t             model_q;
    coord_t                x_q;
    coord_t                y_q;
    coord_t                step_q;
    logic [count_w-1:0]    remain;
    logic                  last_q;
    logic                  xfer;

    assign cmd_ready  = (state == st_idle);
    assign inst_valid = (state == st_emit);
    assign inst_model = model_q;
    assign inst_x     = x_q;
    assign inst_y     = y_q;
    assign inst_last  = last_q && (remain == '0);

    assign xfer = inst_valid && inst_ready;

    // Control state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= st_idle;
            remain <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        state <= st_emit;
                        // Single placement ignores the repeat field
                        remain <= (cmd_op == op_single) ? '0 : cmd_count;
                    end
                end
                st_emit: begin
                    if (xfer) begin
                        if (remain == '0) begin
                            state <= st_idle;
                        end else begin
                            remain <= remain - 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Command latch and position stepping
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            op_q    <= cmd_op;
            model_q <= cmd_model;
            x_q     <= cmd_x;
            y_q     <= cmd_y;
            step_q  <= cmd_step;
            last_q  <= cmd_last;
        end else if (xfer) begin
            if (op_q == op_row || op_q == op_diagonal) begin
                x_q <= x_q + step_q;
            end
            if (op_q == op_column || op_q == op_diagonal) begin
                y_q <= y_q + step_q;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_scene_pipe -f compile.f \
        --Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation result: pass"
    exit 0
fi

echo "Simulation result: fail"
exit 1

// ==== scene_bounds.sv ====
`timescale 1ns/100ps
`default_nettype none

module scene_bounds #(
    parameter int TRANSFORM_COUNT = 50
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,

    input  wire logic                                scene_valid,
    output logic                                     scene_ready,
    input  wire scene_pkg::model_id_t                scene_model,
    input  wire scene_pkg::coord_t                   scene_x,
    input  wire scene_pkg::coord_t                   scene_y,
    input  wire logic                                scene_last,

    output logic                                     result_valid,
    input  wire logic                                result_ready,
    output logic [$clog2(TRANSFORM_COUNT+1)-1:0]     result_count,
    output scene_pkg::coord_t                        result_min_x,
    output scene_pkg::coord_t                        result_max_x,
    output scene_pkg::coord_t                        result_min_y,
    output scene_pkg::coord_t                        result_max_y
);
    import scene_pkg::*;

    localparam int CNT_W = $clog2(TRANSFORM_COUNT + 1);

    logic [CNT_W-1:0] acc_count;
    coord_t           acc_min_x;
    coord_t           acc_max_x;
    coord_t           acc_min_y;
    coord_t           acc_max_y;

    logic [CNT_W-1:0] nxt_count;
    coord_t           nxt_min_x;
    coord_t           nxt_max_x;
    coord_t           nxt_min_y;
    coord_t           nxt_max_y;
    logic             first;
    logic             xfer;

    // Model id is not needed for count or bounds
    assign scene_ready = !result_valid;
    assign xfer        = scene_valid && scene_ready;
    assign first       = (acc_count == '0);

    // Running values including the current instance
    always_comb begin
        nxt_count = acc_count + 1'b1;
        if (first) begin
            nxt_min_x = scene_x;
            nxt_max_x = scene_x;
            nxt_min_y = scene_y;
            nxt_max_y = scene_y;
        end else begin
            nxt_min_x = (scene_x < acc_min_x) ? scene_x : acc_min_x;
            nxt_max_x = (scene_x > acc_max_x) ? scene_x : acc_max_x;
            nxt_min_y = (scene_y < acc_min_y) ? scene_y : acc_min_y;
            nxt_max_y = (scene_y > acc_max_y) ? scene_y : acc_max_y;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_count    <= '0;
            result_valid <= 1'b0;
        end else begin
            if (result_valid && result_ready) begin
                result_valid <= 1'b0;
            end
            if (xfer) begin
                // Scene closes, restart the count for the next one
                acc_count <= scene_last ? '0 : nxt_count;
                if (scene_last) begin
                    result_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            acc_min_x <= nxt_min_x;
            acc_max_x <= nxt_max_x;
            acc_min_y <= nxt_min_y;
            acc_max_y <= nxt_max_y;
            if (scene_last) begin
                result_count <= nxt_count;
                result_min_x <= nxt_min_x;
                result_max_x <= nxt_max_x;
                result_min_y <= nxt_min_y;
                result_max_y <= nxt_max_y;
            end
        end
    end

endmodule

`default_nettype wire

// ==== scene_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module scene_buffer #(
    parameter int SCENE_COUNT     = 2,
    parameter int TRANSFORM_COUNT = 50
) (
    input  wire logic                  clk,
    input  wire logic                  rstn,

    input  wire logic                  inst_valid,
    output logic                       inst_ready,
    input  wire scene_pkg::model_id_t  inst_model,
    input  wire scene_pkg::coord_t     inst_x,
    input  wire scene_pkg::coord_t     inst_y,
    input  wire logic                  inst_last,

    output logic                       scene_valid,
    input  wire logic                  scene_ready,
    output scene_pkg::model_id_t       scene_model,
    output scene_pkg::coord_t          scene_x,
    output scene_pkg::coord_t          scene_y,
    output logic                       scene_last
);
    import scene_pkg::*;

    // Index must be able to hold the full count
    localparam int IDX_W  = $clog2(TRANSFORM_COUNT + 1);
    localparam int SLOT_W = (SCENE_COUNT > 1) ? $clog2(SCENE_COUNT) : 1;

    localparam logic [IDX_W-1:0]  IDX_FULL  = IDX_W'(TRANSFORM_COUNT);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(SCENE_COUNT - 1);

    model_id_t mem_model [SCENE_COUNT][TRANSFORM_COUNT];
    coord_t    mem_x     [SCENE_COUNT][TRANSFORM_COUNT];
    coord_t    mem_y     [SCENE_COUNT][TRANSFORM_COUNT];

    // Index of the last stored instance per slot
    logic [IDX_W-1:0]      slot_size     [SCENE_COUNT];
    logic [SCENE_COUNT-1:0] slot_complete;

    logic [SLOT_W-1:0]     wr_slot;
    logic [SLOT_W-1:0]     rd_slot;
    logic [IDX_W-1:0]      wr_idx;
    logic [IDX_W-1:0]      rd_idx;
    logic                  wr_en;
    logic                  rd_en;
    logic                  rd_done;

    assign inst_ready = !(slot_complete[wr_slot] || (wr_idx == IDX_FULL));
    assign wr_en      = inst_valid && inst_ready;

    assign scene_valid = slot_complete[rd_slot];
    assign scene_model = mem_model[rd_slot][rd_idx];
    assign scene_x     = mem_x[rd_slot][rd_idx];
    assign scene_y     = mem_y[rd_slot][rd_idx];

    assign rd_en      = scene_valid && scene_ready;
    assign rd_done    = (rd_idx == slot_size[rd_slot]);
    assign scene_last = rd_en && rd_done;

    // Instance storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_model[wr_slot][wr_idx] <= inst_model;
            mem_x[wr_slot][wr_idx]     <= inst_x;
            mem_y[wr_slot][wr_idx]     <= inst_y;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_slot       <= '0;
            rd_slot       <= '0;
            wr_idx        <= '0;
            rd_idx        <= '0;
            slot_complete <= '0;
            for (int i = 0; i < SCENE_COUNT; i++) begin
                slot_size[i] <= '0;
            end
        end else begin
            // Write side
            if (wr_en) begin
                slot_size[wr_slot] <= wr_idx;
                wr_idx             <= wr_idx + 1'b1;
                if (inst_last) begin
                    slot_complete[wr_slot] <= 1'b1;
                    wr_idx                 <= '0;
                    wr_slot <= (wr_slot == SLOT_LAST) ? '0 : wr_slot + 1'b1;
                end
            end

            // Read side, write never targets a complete slot
            if (rd_en) begin
                if (!rd_done) begin
                    rd_idx <= rd_idx + 1'b1;
                end else begin
                    slot_complete[rd_slot] <= 1'b0;
                    rd_idx                 <= '0;
                    rd_slot <= (rd_slot == SLOT_LAST) ? '0 : rd_slot + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== scene_pipe_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module scene_pipe_props #(
    parameter int TRANSFORM_COUNT = 50
) (
    input wire logic                                clk,
    input wire logic                                rstn,
    input wire logic                                cmd_valid,
    input wire logic                                cmd_ready,
    input wire logic                                inst_valid,
    input wire logic                                inst_ready,
    input wire scene_pkg::model_id_t                inst_model,
    input wire scene_pkg::coord_t                   inst_x,
    input wire scene_pkg::coord_t                   inst_y,
    input wire logic                                inst_last,
    input wire logic                                scene_valid,
    input wire logic                                scene_ready,
    input wire scene_pkg::model_id_t                scene_model,
    input wire scene_pkg::coord_t                   scene_x,
    input wire scene_pkg::coord_t                   scene_y,
    input wire logic                                result_valid,
    input wire logic                                result_ready,
    input wire logic [$clog2(TRANSFORM_COUNT+1)-1:0] result_count,
    input wire scene_pkg::coord_t                   result_min_x,
    input wire scene_pkg::coord_t                   result_max_x,
    input wire scene_pkg::coord_t                   result_min_y,
    input wire scene_pkg::coord_t                   result_max_y
);

    inst_hold: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid && !inst_ready |=>
            inst_valid && $stable({inst_model, inst_x, inst_y, inst_last}))
        else $error("Instance stream changed while stalled");

    // scene_last depends on ready, so only the data are held
    scene_hold: assert property (@(posedge clk) disable iff (!rstn)
        scene_valid && !scene_ready |=>
            scene_valid && $stable({scene_model, scene_x, scene_y}))
        else $error("Scene stream changed while stalled");

    result_hold: assert property (@(posedge clk) disable iff (!rstn)
        result_valid && !result_ready |=> result_valid && $stable({result_count,
            result_min_x, result_max_x, result_min_y, result_max_y}))
        else $error("Result changed before it was accepted");

    emit_busy: assert property (@(posedge clk) disable iff (!rstn)
        cmd_valid && cmd_ready |=> inst_valid && !cmd_ready)
        else $error("No instance pending after a command was accepted");

    emit_release: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid && inst_ready && inst_last |=> cmd_ready)
        else $error("Command port not ready after the last instance of a scene");

endmodule

bind scene_pipe_top scene_pipe_props #(
    .TRANSFORM_COUNT (TRANSFORM_COUNT)
) i_scene_pipe_props (.*);

`default_nettype wire

// ==== scene_pipe_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module scene_pipe_top #(
    parameter int SCENE_COUNT     = 2,
    parameter int TRANSFORM_COUNT = 50
) (
    input  wire logic                                clk,
    input  wire logic                                rstn,

    input  wire logic                                cmd_valid,
    output logic                                     cmd_ready,
    input  wire scene_pkg::scene_op_e                cmd_op,
    input  wire scene_pkg::model_id_t                cmd_model,
    input  wire scene_pkg::coord_t                   cmd_x,
    input  wire scene_pkg::coord_t                   cmd_y,
    input  wire scene_pkg::coord_t                   cmd_step,
    input  wire logic [scene_pkg::count_w-1:0]       cmd_count,
    input  wire logic                                cmd_last,

    output logic                                     result_valid,
    input  wire logic                                result_ready,
    output logic [$clog2(TRANSFORM_COUNT+1)-1:0]     result_count,
    output scene_pkg::coord_t                        result_min_x,
    output scene_pkg::coord_t                        result_max_x,
    output scene_pkg::coord_t                        result_min_y,
    output scene_pkg::coord_t                        result_max_y
);
    import scene_pkg::*;

    // Instance stream
    logic      inst_valid;
    logic      inst_ready;
    model_id_t inst_model;
    coord_t    inst_x;
    coord_t    inst_y;
    logic      inst_last;

    // Scene stream
    logic      scene_valid;
    logic      scene_ready;
    model_id_t scene_model;
    coord_t    scene_x;
    coord_t    scene_y;
    logic      scene_last;

    instance_emitter i_instance_emitter (
        .clk        (clk),
        .rstn       (rstn),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_model  (cmd_model),
        .cmd_x      (cmd_x),
        .cmd_y      (cmd_y),
        .cmd_step   (cmd_step),
        .cmd_count  (cmd_count),
        .cmd_last   (cmd_last),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_model (inst_model),
        .inst_x     (inst_x),
        .inst_y     (inst_y),
        .inst_last  (inst_last)
    );

    scene_buffer #(
        .SCENE_COUNT     (SCENE_COUNT),
        .TRANSFORM_COUNT (TRANSFORM_COUNT)
    ) i_scene_buffer (
        .clk         (clk),
        .rstn        (rstn),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .inst_model  (inst_model),
        .inst_x      (inst_x),
        .inst_y      (inst_y),
        .inst_last   (inst_last),
        .scene_valid (scene_valid),
        .scene_ready (scene_ready),
        .scene_model (scene_model),
        .scene_x     (scene_x),
        .scene_y     (scene_y),
        .scene_last  (scene_last)
    );

    scene_bounds #(
        .TRANSFORM_COUNT (TRANSFORM_COUNT)
    ) i_scene_bounds (
        .clk          (clk),
        .rstn         (rstn),
        .scene_valid  (scene_valid),
        .scene_ready  (scene_ready),
        .scene_model  (scene_model),
        .scene_x      (scene_x),
        .scene_y      (scene_y),
        .scene_last   (scene_last),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_count (result_count),
        .result_min_x (result_min_x),
        .result_max_x (result_max_x),
        .result_min_y (result_min_y),
        .result_max_y (result_max_y)
    );

endmodule

`default_nettype wire

// ==== scene_pkg.sv ====
`default_nettype none

package scene_pkg;

    // Coordinate and model widths
    localparam int coord_w = 16;
    localparam int model_w = 8;

    // Width of the repeat field in a placement command
    localparam int count_w = 6;

    // Unsigned, wraps modulo 2^16
    typedef logic [coord_w-1:0] coord_t;

    typedef logic [model_w-1:0] model_id_t;

    // Placement command opcodes
    typedef enum logic [1:0] {
        op_single   = 2'd0,
        op_row      = 2'd1,
        op_column   = 2'd2,
        op_diagonal = 2'd3
    } scene_op_e;

endpackage

`default_nettype wire

// ==== tb_scene_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_scene_pipe;
    import scene_pkg::*;

    localparam int SCENE_COUNT     = 2;
    localparam int TRANSFORM_COUNT = 50;
    localparam int CNT_W           = $clog2(TRANSFORM_COUNT + 1);
    localparam int N_DIRECTED      = 7;
    localparam int N_RANDOM        = 40;
    localparam int N_SCENES        = N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT_CYCLES  = N_SCENES * 200 + 400;

    typedef struct packed {
        scene_op_e          op;
        model_id_t          model;
        coord_t             x;
        coord_t             y;
        coord_t             step;
        logic [count_w-1:0] count;
    } cmd_s;

    typedef struct packed {
        int unsigned count;
        coord_t      min_x;
        coord_t      max_x;
        coord_t      min_y;
        coord_t      max_y;
    } result_s;

    logic               clk;
    logic               rstn;
    logic               cmd_valid;
    logic               cmd_ready;
    scene_op_e          cmd_op;
    model_id_t          cmd_model;
    coord_t             cmd_x;
    coord_t             cmd_y;
    coord_t             cmd_step;
    logic [count_w-1:0] cmd_count;
    logic               cmd_last;
    logic               result_valid;
    logic               result_ready;
    logic [CNT_W-1:0]   result_count;
    coord_t             result_min_x;
    coord_t             result_max_x;
    coord_t             result_min_y;
    coord_t             result_max_y;

    logic [31:0] lfsr_q;
    cmd_s        cmds_buf [4];
    result_s     exp_q [$];
    string       name_q [$];
    int          checked;
    int          scene_len;

    scene_pipe_top #(
        .SCENE_COUNT     (SCENE_COUNT),
        .TRANSFORM_COUNT (TRANSFORM_COUNT)
    ) i_scene_pipe_top (
        .clk          (clk),
        .rstn         (rstn),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_model    (cmd_model),
        .cmd_x        (cmd_x),
        .cmd_y        (cmd_y),
        .cmd_step     (cmd_step),
        .cmd_count    (cmd_count),
        .cmd_last     (cmd_last),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_count (result_count),
        .result_min_x (result_min_x),
        .result_max_x (result_max_x),
        .result_min_y (result_min_y),
        .result_max_y (result_max_y)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // Walks every instance of the scene with 16-bit wrap
    function automatic result_s expect_bounds(input cmd_s cmds [4], input int n);
        result_s r;
        coord_t  px;
        coord_t  py;
        int      k;
        r = '{count: 0, min_x: '1, max_x: '0, min_y: '1, max_y: '0};
        for (int c = 0; c < n; c++) begin
            k  = (cmds[c].op == op_single) ? 1 : int'(cmds[c].count) + 1;
            px = cmds[c].x;
            py = cmds[c].y;
            for (int i = 0; i < k; i++) begin
                r.count = r.count + 1;
                r.min_x = (px < r.min_x) ? px : r.min_x;
                r.max_x = (px > r.max_x) ? px : r.max_x;
                r.min_y = (py < r.min_y) ? py : r.min_y;
                r.max_y = (py > r.max_y) ? py : r.max_y;
                if (cmds[c].op == op_row || cmds[c].op == op_diagonal) begin
                    px = px + cmds[c].step;
                end
                if (cmds[c].op == op_column || cmds[c].op == op_diagonal) begin
                    py = py + cmds[c].step;
                end
            end
        end
        return r;
    endfunction

    task automatic set_cmd(input int idx, input scene_op_e op, input coord_t x, input coord_t y,
                           input coord_t step, input int count);
        cmds_buf[idx] = '{op: op, model: 8'(rand_bits(8)), x: x, y: y, step: step,
                          count: count_w'(count)};
    endtask

    // Up to 4 commands whose instances fit in one slot
    task automatic random_scene(output int n);
        logic [31:0] r;
        int          budget;
        int          k;
        n      = 1 + int'(rand_bits(2));
        budget = TRANSFORM_COUNT - (n - 1);
        for (int c = 0; c < n; c++) begin
            r = rand_bits(2);
            set_cmd(c, scene_op_e'(r[1:0]), 16'(rand_bits(16)), 16'(rand_bits(16)),
                    16'(rand_bits(16)), int'(rand_bits(4)));
            k = (cmds_buf[c].op == op_single) ? 1 : int'(cmds_buf[c].count) + 1;
            if (k > budget) begin
                cmds_buf[c].count = count_w'(budget - 1);
                k = budget;
            end
            budget = budget - k + 1;
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic send_cmd(input cmd_s c, input logic last);
        cmd_valid = 1'b1;
        cmd_op    = c.op;
        cmd_model = c.model;
        cmd_x     = c.x;
        cmd_y     = c.y;
        cmd_step  = c.step;
        cmd_count = c.count;
        cmd_last  = last;
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic run_scene(input string name, input int n);
        exp_q.push_back(expect_bounds(cmds_buf, n));
        name_q.push_back(name);
        for (int c = 0; c < n; c++) begin
            send_cmd(cmds_buf[c], c == n - 1);
        end
    endtask

    task automatic check_field(input string name, input string field, input int unsigned exp,
                               input int unsigned act);
        assert (exp == act) else begin
            $display("Fail %s %s expected 0x%0h actual 0x%0h", name, field, exp, act);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic compare_result();
        result_s exp;
        string   name;
        assert (exp_q.size() > 0) else begin
            $display("A result arrived while no scene was pending");
            $display("*** FAILED ***");
            $fatal(1);
        end
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        check_field(name, "count", exp.count, 32'(result_count));
        check_field(name, "min_x", 32'(exp.min_x), 32'(result_min_x));
        check_field(name, "max_x", 32'(exp.max_x), 32'(result_max_x));
        check_field(name, "min_y", 32'(exp.min_y), 32'(result_min_y));
        check_field(name, "max_y", 32'(exp.max_y), 32'(result_max_y));
        checked = checked + 1;
    endtask

    // Results are stable at the falling edge before they transfer
    initial begin
        forever begin
            @(negedge clk);
            if (rstn && result_valid && result_ready) begin
                compare_result();
            end
        end
    end

    // Random stalls on the result port
    initial begin
        int stall;
        stall = 0;
        @(posedge rstn);
        forever begin
            @(negedge clk);
            if (stall > 0) begin
                stall = stall - 1;
            end else if (rand_bits(3) == 0) begin
                stall = 1 + int'(rand_bits(4));
            end
            @(posedge clk);
            #2;
            result_ready = (stall == 0);
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, no result arrived for %0d scenes",
                 TIMEOUT_CYCLES, N_SCENES - checked);
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        lfsr_q       = 32'h739;
        checked      = 0;
        rstn         = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = op_single;
        cmd_model    = '0;
        cmd_x        = '0;
        cmd_y        = '0;
        cmd_step     = '0;
        cmd_count    = '0;
        cmd_last     = 1'b0;
        result_ready = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;

        set_cmd(0, op_single, 16'h1234, 16'habcd, 16'h0000, 0);
        run_scene("single_mid", 1);
        // Count field must be ignored here
        set_cmd(0, op_single, 16'hffff, 16'h0000, 16'h0010, 5);
        run_scene("single_edge", 1);
        set_cmd(0, op_row, 16'hfff0, 16'h0100, 16'h0008, 5);
        run_scene("row_wrap", 1);
        set_cmd(0, op_column, 16'h0200, 16'hfffe, 16'h0001, 7);
        run_scene("column_wrap", 1);
        set_cmd(0, op_diagonal, 16'h8000, 16'h7ff0, 16'h1000, 9);
        run_scene("diagonal_wrap", 1);
        set_cmd(0, op_row, 16'd10, 16'd20, 16'd3, 4);
        set_cmd(1, op_column, 16'd5, 16'd100, 16'd7, 2);
        set_cmd(2, op_single, 16'd300, 16'd1, 16'd0, 0);
        run_scene("multi_cmd", 3);
        // Two 25-instance commands fill the slot
        set_cmd(0, op_row, 16'd0, 16'd0, 16'd1, 24);
        set_cmd(1, op_column, 16'd40, 16'd40, 16'd2, 24);
        run_scene("full_slot", 2);

        for (int s = 0; s < N_RANDOM; s++) begin
            random_scene(scene_len);
            run_scene($sformatf("random_%0d", s), scene_len);
        end

        wait (checked == N_SCENES);
        repeat (10) @(posedge clk);
        if (!result_valid) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Results left over after all %0d scenes were checked", N_SCENES);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
